// ==== bench/shared_alu_assertions.sv ====
// Handshake and arbiter assertions
`timescale 1ns/1ps
`default_nettype none

module shared_alu_assertions
    import arb_pkg::*;
#(
    parameter int NUM_REQ = 4
) (
    input wire               clk,
    input wire               rst_n,
    input wire [NUM_REQ-1:0] req_i,
    input wire [NUM_REQ-1:0] ack_i,
    input wire               release_i,
    input wire [1:0]         state_i
);

    ack_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ack_i))
        else $error("more than one ack is high");

    // an ack only rises for a requester that was requesting at that edge
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        ((ack_i & ~$past(ack_i) & ~$past(req_i)) == '0))
        else $error("ack rose while its req was low");

    // release passes through ARB_RELEASE, idle two edges later
    release_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $past(release_i, 2) |-> (state_i == ARB_IDLE))
        else $error("arbiter did not return to idle after release");

    ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        ((~ack_i & $past(ack_i) & $past(req_i)) == '0))
        else $error("ack fell while its req was still high");

endmodule : shared_alu_assertions

bind shared_alu_top shared_alu_assertions #(.NUM_REQ(NUM_REQ)) u_assertions (
    .clk(clk), .rst_n(rst_n), .req_i(req_i), .ack_i(ack_o),
    .release_i(rel_pulse), .state_i(u_arbiter.state)
);

`default_nettype wire

// ==== bench/tb_shared_alu.sv ====
// Shared ALU testbench
`timescale 1ns/1ps
`default_nettype none

module tb_shared_alu
    import alu_pkg::*;
();

    localparam int NUM_REQ = 4;
    localparam int DATA_W  = 16;
    localparam int IDX_W   = $clog2(NUM_REQ);
    localparam int TIMEOUT = 50;

    logic                        clk;
    logic                        rst_n;
    logic [NUM_REQ-1:0]          req;
    logic [NUM_REQ*ALU_OP_W-1:0] op_bus;
    logic [NUM_REQ*DATA_W-1:0]   a_bus;
    logic [NUM_REQ*DATA_W-1:0]   b_bus;
    wire  [NUM_REQ-1:0]          ack;
    wire  [DATA_W-1:0]           result;
    wire                         zero;

    // copies of each requester's command for the reference model
    alu_op_t           cmd_op [NUM_REQ];
    logic [DATA_W-1:0] cmd_a  [NUM_REQ];
    logic [DATA_W-1:0] cmd_b  [NUM_REQ];
    logic [15:0]       lfsr;

    shared_alu_top #(.NUM_REQ(NUM_REQ), .DATA_W(DATA_W)) UUT (
        .clk(clk), .rst_n(rst_n), .req_i(req),
        .op_i(op_bus), .a_i(a_bus), .b_i(b_bus),
        .ack_o(ack), .result_o(result), .zero_o(zero)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [DATA_W-1:0] take_bits(input int n);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[DATA_W-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] alu_model(input alu_op_t op,
                                                    input logic [DATA_W-1:0] a,
                                                    input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SHL:  r = a << b[3:0];
            OP_SHR:  r = a >> b[3:0];
            default: r = a;
        endcase
        return r;
    endfunction

    task automatic check_result(input logic [DATA_W-1:0] expected);
        if (result !== expected || zero !== (expected == '0)) begin
            stop_with_failure($sformatf("FAILED at %0t: result %h zero %b, expected %h",
                                        $time, result, zero, expected));
        end
    endtask

    task automatic check_grant(input logic [IDX_W-1:0] expected);
        logic [NUM_REQ-1:0] onehot;
        onehot = {{(NUM_REQ-1){1'b0}}, 1'b1} << expected;
        if (ack !== onehot) begin
            stop_with_failure($sformatf("FAILED at %0t: ack %b, expected grant to %0d",
                                        $time, ack, expected));
        end
    endtask

    task automatic set_cmd(input int idx, input alu_op_t op,
                           input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        cmd_op[idx] = op;
        cmd_a[idx]  = a;
        cmd_b[idx]  = b;
        op_bus[idx*ALU_OP_W +: ALU_OP_W] = op;
        a_bus[idx*DATA_W +: DATA_W]      = a;
        b_bus[idx*DATA_W +: DATA_W]      = b;
    endtask

    task automatic set_random_cmd(input int idx, input alu_op_t op);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        a = take_bits(DATA_W);
        b = take_bits(DATA_W);
        set_cmd(idx, op, a, b);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        req   = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic await_grant(input int idx);
        int n;
        n = 0;
        while (ack == '0) begin
            if (n == TIMEOUT) begin
                stop_with_failure($sformatf("no ack arrived for requester %0d", idx));
            end
            @(negedge clk);
            n++;
        end
        check_grant(IDX_W'(idx));
        check_result(alu_model(cmd_op[idx], cmd_a[idx], cmd_b[idx]));
    endtask

    task automatic hold_grant(input int idx, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_grant(IDX_W'(idx));
            check_result(alu_model(cmd_op[idx], cmd_a[idx], cmd_b[idx]));
        end
    endtask

    task automatic finish_grant(input int idx);
        int n;
        n = 0;
        req[idx] = 1'b0;
        while (ack[idx]) begin
            if (n == TIMEOUT) begin
                stop_with_failure($sformatf("ack of requester %0d never fell", idx));
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic serve(input int idx);
        await_grant(idx);
        finish_grant(idx);
    endtask

    task automatic sweep_opcodes();
        for (int k = 0; k < 8; k++) begin
            set_random_cmd(0, alu_op_t'(k));
            req[0] = 1'b1;
            serve(0);
        end
    endtask

    task automatic hold_then_release();
        int hold;
        hold = int'(take_bits(3)) + 1;
        set_random_cmd(2, OP_ADD);
        req[2] = 1'b1;
        await_grant(2);
        hold_grant(2, hold);
        finish_grant(2);
        repeat (6) begin
            @(negedge clk);
            if (ack != '0) begin
                stop_with_failure("an ack appeared while no request was pending");
            end
        end
    endtask

    // reset ranks favour the lower index
    task automatic order_from_reset();
        apply_reset();
        for (int i = 0; i < NUM_REQ; i++) begin
            set_random_cmd(i, alu_op_t'(i));
        end
        req = '1;
        for (int i = 0; i < NUM_REQ; i++) begin
            serve(i);
        end
    endtask

    // after 2 is served its rank is newest, 3 then sits below it
    task automatic reorder_after_history();
        apply_reset();
        set_random_cmd(2, OP_OR);
        req[2] = 1'b1;
        serve(2);
        set_random_cmd(1, OP_ADD);
        set_random_cmd(2, OP_SUB);
        set_random_cmd(3, OP_SHR);
        req[3:1] = 3'b111;
        serve(1);
        serve(3);
        serve(2);
    endtask

    task automatic zero_results();
        logic [DATA_W-1:0] x;
        x = take_bits(DATA_W);
        set_cmd(0, OP_SUB, x, x);
        req[0] = 1'b1;
        serve(0);
        set_cmd(0, OP_AND, x, ~x);
        req[0] = 1'b1;
        serve(0);
    endtask

    task automatic wait_behind_holder();
        int hold;
        hold = int'(take_bits(3)) + 2;
        set_random_cmd(1, OP_SHL);
        set_random_cmd(3, OP_SUB);
        req[1] = 1'b1;
        await_grant(1);
        // 3 waits behind the held ack of 1
        req[3] = 1'b1;
        hold_grant(1, hold);
        finish_grant(1);
        serve(3);
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        req    = '0;
        op_bus = '0;
        a_bus  = '0;
        b_bus  = '0;
        lfsr   = 16'd31460;
        apply_reset();
        sweep_opcodes();
        hold_then_release();
        order_from_reset();
        reorder_after_history();
        zero_results();
        wait_behind_holder();
        $display("Result: PASSED");
        $finish;
    end

endmodule : tb_shared_alu

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the shared ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f shared_alu_top.f \
    --top-module tb_shared_alu --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== shared_alu_top.f ====
src/arb_pkg.sv
src/alu_pkg.sv
src/lru_arbiter.sv
src/cmd_decode.sv
src/alu_execute.sv
src/result_return.sv
src/shared_alu_top.sv
bench/shared_alu_assertions.sv
bench/tb_shared_alu.sv

// ==== src/alu_execute.sv ====
// ALU execute stage
`timescale 1ns/1ps
`default_nettype none

module alu_execute #(
    parameter int DATA_W = 16,
    parameter int IDX_W  = 2
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               dec_valid_i,
    input  wire  [IDX_W-1:0]  dec_idx_i,
    input  wire  [DATA_W-1:0] opa_i,
    input  wire  [DATA_W-1:0] opb_i,
    input  wire               sub_en_i,
    input  wire  [1:0]        logic_sel_i,
    input  wire               shift_en_i,
    input  wire               shift_dir_i,
    input  wire               pass_i,
    output logic              exe_valid_o,
    output logic [IDX_W-1:0]  exe_idx_o,
    output logic [DATA_W-1:0] exe_result_o,
    output logic              exe_zero_o
);

    logic [DATA_W-1:0] b_eff;
    logic [DATA_W-1:0] sum;
    logic [DATA_W-1:0] shifted;
    logic [3:0]        shamt;
    logic [DATA_W-1:0] res_next;

    // subtract is a + ~b + 1
    assign b_eff   = sub_en_i ? ~opb_i : opb_i;
    assign sum     = opa_i + b_eff + {{(DATA_W-1){1'b0}}, sub_en_i};
    assign shamt   = opb_i[3:0];
    assign shifted = shift_dir_i ? (opa_i >> shamt) : (opa_i << shamt);

    always_comb begin
        if (pass_i) begin
            res_next = opa_i;
        end else if (shift_en_i) begin
            res_next = shifted;
        end else begin
            case (logic_sel_i)
                2'd1:    res_next = opa_i & opb_i;
                2'd2:    res_next = opa_i | opb_i;
                2'd3:    res_next = opa_i ^ opb_i;
                default: res_next = sum;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid_o <= 1'b0;
        end else begin
            exe_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            exe_idx_o    <= dec_idx_i;
            exe_result_o <= res_next;
            exe_zero_o   <= (res_next == '0);
        end
    end

endmodule : alu_execute

`default_nettype wire

// ==== src/alu_pkg.sv ====
// ALU opcode definitions
`default_nettype none

package alu_pkg;

    // width of one opcode field in the flattened op bus
    localparam int ALU_OP_W = 3;

    // shifts use the low four bits of operand b
    // pass returns operand a unchanged
    typedef enum logic [ALU_OP_W-1:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SHL  = 3'd5,
        OP_SHR  = 3'd6,
        OP_PASS = 3'd7
    } alu_op_t;

endpackage : alu_pkg

`default_nettype wire

// ==== src/arb_pkg.sv ====
// Arbitration types
`default_nettype none

package arb_pkg;

    // arbiter FSM
    // IDLE picks a winner from the sampled requests, BUSY holds the grant
    // for the whole four-phase transaction, RELEASE is the one-cycle gap
    // where the recency ranks have just been updated
    typedef enum logic [1:0] {
        ARB_IDLE    = 2'd0,
        ARB_BUSY    = 2'd1,
        ARB_RELEASE = 2'd2
    } arb_state_t;

endpackage : arb_pkg

`default_nettype wire

// ==== src/cmd_decode.sv ====
// Command decode stage
`timescale 1ns/1ps
`default_nettype none

module cmd_decode
    import alu_pkg::*;
#(
    parameter int NUM_REQ = 4,
    parameter int DATA_W  = 16,
    parameter int IDX_W   = $clog2(NUM_REQ)
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         grant_valid_i,
    input  wire  [IDX_W-1:0]            grant_idx_i,
    input  wire  [NUM_REQ*ALU_OP_W-1:0] op_i,
    input  wire  [NUM_REQ*DATA_W-1:0]   a_i,
    input  wire  [NUM_REQ*DATA_W-1:0]   b_i,
    output logic                        dec_valid_o,
    output logic [IDX_W-1:0]            dec_idx_o,
    output logic [DATA_W-1:0]           opa_o,
    output logic [DATA_W-1:0]           opb_o,
    output logic                        sub_en_o,
    output logic [1:0]                  logic_sel_o,
    output logic                        shift_en_o,
    output logic                        shift_dir_o,
    output logic                        pass_o
);

    alu_op_t    op_sel;
    logic       sub_en;
    logic [1:0] logic_sel;
    logic       shift_en;
    logic       shift_dir;
    logic       pass;

    assign op_sel = alu_op_t'(op_i[grant_idx_i*ALU_OP_W +: ALU_OP_W]);

    // logic_sel: 0 adder, 1 and, 2 or, 3 xor
    always_comb begin
        sub_en    = 1'b0;
        logic_sel = 2'd0;
        shift_en  = 1'b0;
        shift_dir = 1'b0;
        pass      = 1'b0;
        case (op_sel)
            OP_ADD: ;
            OP_SUB: sub_en = 1'b1;
            OP_AND: logic_sel = 2'd1;
            OP_OR:  logic_sel = 2'd2;
            OP_XOR: logic_sel = 2'd3;
            OP_SHL: shift_en = 1'b1;
            OP_SHR: begin
                shift_en  = 1'b1;
                shift_dir = 1'b1;
            end
            default: pass = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= grant_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid_i) begin
            dec_idx_o   <= grant_idx_i;
            opa_o       <= a_i[grant_idx_i*DATA_W +: DATA_W];
            opb_o       <= b_i[grant_idx_i*DATA_W +: DATA_W];
            sub_en_o    <= sub_en;
            logic_sel_o <= logic_sel;
            shift_en_o  <= shift_en;
            shift_dir_o <= shift_dir;
            pass_o      <= pass;
        end
    end

endmodule : cmd_decode

`default_nettype wire

// ==== src/lru_arbiter.sv ====
// LRU arbiter
`timescale 1ns/1ps
`default_nettype none

module lru_arbiter
    import arb_pkg::*;
#(
    parameter int NUM_REQ = 4,
    parameter int IDX_W   = $clog2(NUM_REQ)
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire  [NUM_REQ-1:0] req_i,
    input  wire                release_i,
    output logic               grant_valid_o,
    output logic [IDX_W-1:0]   grant_idx_o
);

    arb_state_t         state;
    logic [NUM_REQ-1:0] req_q;
    logic [IDX_W-1:0]   rank [NUM_REQ];
    logic [IDX_W-1:0]   lru_idx;
    logic [IDX_W-1:0]   best_rank;
    logic               found;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= '0;
        end else begin
            req_q <= req_i;
        end
    end

    // lowest rank among pending requests wins
    always_comb begin
        lru_idx   = '0;
        best_rank = '1;
        found     = 1'b0;
        for (int i = 0; i < NUM_REQ; i++) begin
            if (req_q[i] && (!found || rank[i] < best_rank)) begin
                lru_idx   = IDX_W'(i);
                best_rank = rank[i];
                found     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ARB_IDLE;
            grant_valid_o <= 1'b0;
            grant_idx_o   <= '0;
            for (int i = 0; i < NUM_REQ; i++) begin
                rank[i] <= IDX_W'(i);
            end
        end else begin
            grant_valid_o <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        grant_valid_o <= 1'b1;
                        grant_idx_o   <= lru_idx;
                        state         <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (release_i) begin
                        // winner becomes most recent, younger ones age by one
                        for (int i = 0; i < NUM_REQ; i++) begin
                            if (i == int'(grant_idx_o)) begin
                                rank[i] <= IDX_W'(NUM_REQ - 1);
                            end else if (rank[i] > rank[grant_idx_o]) begin
                                rank[i] <= rank[i] - 1'b1;
                            end
                        end
                        state <= ARB_RELEASE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

endmodule : lru_arbiter

`default_nettype wire

// ==== src/result_return.sv ====
// Result return and ack stage
`timescale 1ns/1ps
`default_nettype none

module result_return #(
    parameter int NUM_REQ = 4,
    parameter int DATA_W  = 16,
    parameter int IDX_W   = $clog2(NUM_REQ)
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                exe_valid_i,
    input  wire  [IDX_W-1:0]   exe_idx_i,
    input  wire  [DATA_W-1:0]  exe_result_i,
    input  wire                exe_zero_i,
    input  wire  [NUM_REQ-1:0] req_i,
    output logic [NUM_REQ-1:0] ack_o,
    output logic [DATA_W-1:0]  result_o,
    output logic               zero_o,
    output logic               release_o
);

    logic [NUM_REQ-1:0] ack_q;
    logic [NUM_REQ-1:0] ack_set;
    logic [DATA_W-1:0]  result_q;
    logic               zero_q;
    logic               req_drop;

    // one-hot ack for the carried index
    assign ack_set = {{(NUM_REQ-1){1'b0}}, 1'b1} << exe_idx_i;

    // acked requester has dropped its req
    assign req_drop = |(ack_q & ~req_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q     <= '0;
            release_o <= 1'b0;
        end else begin
            release_o <= 1'b0;
            if (exe_valid_i) begin
                ack_q <= ack_set;
            end else if (req_drop) begin
                // ack falls and the arbiter is told in the same edge
                ack_q     <= '0;
                release_o <= 1'b1;
            end
        end
    end

    // result held for as long as the ack stays up
    always_ff @(posedge clk) begin
        if (exe_valid_i) begin
            result_q <= exe_result_i;
            zero_q   <= exe_zero_i;
        end
    end

    assign ack_o    = ack_q;
    assign result_o = result_q;
    assign zero_o   = zero_q;

endmodule : result_return

`default_nettype wire

// ==== src/shared_alu_top.sv ====
// Shared ALU top level
`timescale 1ns/1ps
`default_nettype none

module shared_alu_top
    import alu_pkg::*;
#(
    parameter int NUM_REQ = 4,
    parameter int DATA_W  = 16
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  [NUM_REQ-1:0]          req_i,
    input  wire  [NUM_REQ*ALU_OP_W-1:0] op_i,
    input  wire  [NUM_REQ*DATA_W-1:0]   a_i,
    input  wire  [NUM_REQ*DATA_W-1:0]   b_i,
    output wire  [NUM_REQ-1:0]          ack_o,
    output wire  [DATA_W-1:0]           result_o,
    output wire                         zero_o
);

    localparam int IDX_W = $clog2(NUM_REQ);

    logic              grant_valid;
    logic [IDX_W-1:0]  grant_idx;
    logic              dec_valid;
    logic [IDX_W-1:0]  dec_idx;
    logic [DATA_W-1:0] opa;
    logic [DATA_W-1:0] opb;
    logic              sub_en;
    logic [1:0]        logic_sel;
    logic              shift_en;
    logic              shift_dir;
    logic              pass;
    logic              exe_valid;
    logic [IDX_W-1:0]  exe_idx;
    logic [DATA_W-1:0] exe_result;
    logic              exe_zero;
    logic              rel_pulse;

    lru_arbiter #(.NUM_REQ(NUM_REQ), .IDX_W(IDX_W)) u_arbiter (
        .clk(clk), .rst_n(rst_n),
        .req_i(req_i), .release_i(rel_pulse),
        .grant_valid_o(grant_valid), .grant_idx_o(grant_idx)
    );

    cmd_decode #(.NUM_REQ(NUM_REQ), .DATA_W(DATA_W), .IDX_W(IDX_W)) u_decode (
        .clk(clk), .rst_n(rst_n),
        .grant_valid_i(grant_valid), .grant_idx_i(grant_idx),
        .op_i(op_i), .a_i(a_i), .b_i(b_i),
        .dec_valid_o(dec_valid), .dec_idx_o(dec_idx),
        .opa_o(opa), .opb_o(opb),
        .sub_en_o(sub_en), .logic_sel_o(logic_sel),
        .shift_en_o(shift_en), .shift_dir_o(shift_dir), .pass_o(pass)
    );

    alu_execute #(.DATA_W(DATA_W), .IDX_W(IDX_W)) u_execute (
        .clk(clk), .rst_n(rst_n),
        .dec_valid_i(dec_valid), .dec_idx_i(dec_idx),
        .opa_i(opa), .opb_i(opb),
        .sub_en_i(sub_en), .logic_sel_i(logic_sel),
        .shift_en_i(shift_en), .shift_dir_i(shift_dir), .pass_i(pass),
        .exe_valid_o(exe_valid), .exe_idx_o(exe_idx),
        .exe_result_o(exe_result), .exe_zero_o(exe_zero)
    );

    result_return #(.NUM_REQ(NUM_REQ), .DATA_W(DATA_W), .IDX_W(IDX_W)) u_result (
        .clk(clk), .rst_n(rst_n),
        .exe_valid_i(exe_valid), .exe_idx_i(exe_idx),
        .exe_result_i(exe_result), .exe_zero_i(exe_zero),
        .req_i(req_i),
        .ack_o(ack_o), .result_o(result_o), .zero_o(zero_o),
        .release_o(rel_pulse)
    );

endmodule : shared_alu_top

`default_nettype wire
